// ==== backend_if.sv ====
`timescale 1ns/1ns

interface dispatch_regfile
    import backend_pkg::*;
();

    // rj and rk of each lane
    logic [2*ISSUE_WIDTH-1:0][REG_ADDR_WIDTH-1:0] raddr;
    bus32_t [2*ISSUE_WIDTH-1:0] rdata;

    modport master(
        output raddr,
        input rdata
    );

    modport slave(
        input raddr,
        output rdata
    );

endinterface

// ==== backend_pkg.sv ====
package backend_pkg;

    localparam int ISSUE_WIDTH = 2;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int PIPE_WIDTH = 4;

    typedef logic [31:0] bus32_t;

    // LoongArch major opcode fields
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_AND = 17'h00029;
    localparam logic [16:0] OP_OR = 17'h0002a;
    localparam logic [16:0] OP_XOR = 17'h0002b;
    localparam logic [16:0] OP_MUL_W = 17'h00038;
    localparam logic [9:0] OP_ADDI_W = 10'h00a;
    localparam logic [6:0] OP_LU12I_W = 7'h0a;
    localparam logic [5:0] OP_B = 6'h14;
    localparam logic [5:0] OP_BEQ = 6'h16;
    localparam logic [5:0] OP_BNE = 6'h17;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI,
        ALU_MUL,
        ALU_BEQ,
        ALU_BNE,
        ALU_B
    } alu_op_t;

    typedef struct packed {
        logic valid;
        bus32_t pc;
        bus32_t inst;
        alu_op_t alu_op;
        logic [REG_ADDR_WIDTH-1:0] rj;
        logic [REG_ADDR_WIDTH-1:0] rk;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic we;
        logic imm_sel;
        bus32_t imm;
        bus32_t br_off;
    } id_dispatch_t;

    typedef struct packed {
        logic valid;
        bus32_t pc;
        bus32_t inst;
        alu_op_t alu_op;
        bus32_t src1;
        bus32_t src2;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic we;
        bus32_t br_off;
    } dispatch_ex_t;

    typedef struct packed {
        logic valid;
        bus32_t pc;
        bus32_t inst;
        logic we;
        logic [REG_ADDR_WIDTH-1:0] rd;
        bus32_t result;
    } ex_wb_t;

    typedef struct packed {
        logic we;
        logic [REG_ADDR_WIDTH-1:0] rd;
        bus32_t data;
    } reg_pf_t;

    typedef struct packed {
        logic pause_decoder;
        logic pause_dispatch;
        logic pause_execute;
    } pause_t;

endpackage

// ==== backend_top.sv ====
`timescale 1ns/1ns

module backend_top
    import backend_pkg::*;
(
    input logic clk,
    input logic reset_i,

    // instruction buffer
    input bus32_t [ISSUE_WIDTH-1:0] pc_i,
    input bus32_t [ISSUE_WIDTH-1:0] inst_i,
    input logic [ISSUE_WIDTH-1:0] inst_valid_i,
    output logic [ISSUE_WIDTH-1:0] send_inst_en_o,

    // to pc
    output logic branch_flush_o,
    output bus32_t new_pc_o,

    // debug
    output logic [31:0] debug_wb_pc_o[2],
    output logic [31:0] debug_wb_inst_o[2],
    output logic [3:0] debug_wb_rf_wen_o[2],
    output logic [4:0] debug_wb_rf_wnum_o[2],
    output logic [31:0] debug_wb_rf_wdata_o[2]
);

    dispatch_regfile dispatch_regfile_io ();

    pause_t pause_request;
    logic [PIPE_WIDTH-1:0] pause;
    logic [PIPE_WIDTH-1:0] flush;

    id_dispatch_t [ISSUE_WIDTH-1:0] dispatch_i;
    dispatch_ex_t [ISSUE_WIDTH-1:0] ex_i;
    ex_wb_t [ISSUE_WIDTH-1:0] wb_i;
    ex_wb_t [ISSUE_WIDTH-1:0] wb_o;
    reg_pf_t [ISSUE_WIDTH-1:0] ex_reg_pf;
    reg_pf_t [ISSUE_WIDTH-1:0] wb_reg_pf;

    logic [ISSUE_WIDTH-1:0] reg_write_en;
    logic [ISSUE_WIDTH-1:0][REG_ADDR_WIDTH-1:0] reg_write_addr;
    bus32_t [ISSUE_WIDTH-1:0] reg_write_data;

    // only the multiplier stalls in this back end
    assign pause_request.pause_decoder = 1'b0;
    assign pause_request.pause_dispatch = 1'b0;

    decoder u_decoder (
        .clk,
        .reset_i,
        .pause_i(pause[0]),
        .flush_i(flush[0]),
        .pc_i,
        .inst_i,
        .inst_valid_i,
        .send_inst_en_o,
        .dispatch_o(dispatch_i)
    );

    dispatch u_dispatch (
        .clk,
        .reset_i,
        .pause_i(pause[1]),
        .flush_i(flush[1]),
        .dispatch_i,
        .ex_reg_pf_i(ex_reg_pf),
        .wb_reg_pf_i(wb_reg_pf),
        .regfile_master(dispatch_regfile_io.master),
        .ex_o(ex_i)
    );

    execute u_execute (
        .clk,
        .reset_i,
        .ex_i,
        .pause_request_o(pause_request.pause_execute),
        .branch_flush_o,
        .new_pc_o,
        .ex_reg_pf_o(ex_reg_pf),
        .wb_o(wb_i)
    );

    wb u_wb (
        .clk,
        .reset_i,
        .flush_i(flush[3]),
        .wb_i,
        .wb_reg_pf_o(wb_reg_pf),
        .wb_o
    );

    ctrl u_ctrl (
        .pause_request_i(pause_request),
        .branch_flush_i(branch_flush_o),
        .commit_i(wb_o),
        .pause_o(pause),
        .flush_o(flush),
        .we_o(reg_write_en),
        .waddr_o(reg_write_addr),
        .wdata_o(reg_write_data)
    );

    regfile u_regfile (
        .clk,
        .reset_i,
        .we_i(reg_write_en),
        .waddr_i(reg_write_addr),
        .wdata_i(reg_write_data),
        .slave(dispatch_regfile_io.slave)
    );

    generate
        for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_debug
            assign debug_wb_pc_o[i] = wb_o[i].pc;
            assign debug_wb_inst_o[i] = wb_o[i].inst;
            assign debug_wb_rf_wen_o[i] = {4{wb_o[i].valid && wb_o[i].we}};
            assign debug_wb_rf_wnum_o[i] = wb_o[i].rd;
            assign debug_wb_rf_wdata_o[i] = wb_o[i].result;
        end
    endgenerate

endmodule

// ==== ctrl.sv ====
`timescale 1ns/1ns

module ctrl
    import backend_pkg::*;
(
    input pause_t pause_request_i,
    input logic branch_flush_i,
    input ex_wb_t [ISSUE_WIDTH-1:0] commit_i,
    output logic [PIPE_WIDTH-1:0] pause_o,
    output logic [PIPE_WIDTH-1:0] flush_o,
    output logic [ISSUE_WIDTH-1:0] we_o,
    output logic [ISSUE_WIDTH-1:0][REG_ADDR_WIDTH-1:0] waddr_o,
    output bus32_t [ISSUE_WIDTH-1:0] wdata_o
);

    // a stall holds its own stage and every older one, wb takes bubbles
    always_comb begin
        pause_o = '0;
        pause_o[2] = pause_request_i.pause_execute;
        pause_o[1] = pause_o[2] || pause_request_i.pause_dispatch;
        pause_o[0] = pause_o[1] || pause_request_i.pause_decoder;
        flush_o = '0;
        flush_o[0] = branch_flush_i;
        flush_o[1] = branch_flush_i;
    end

    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            we_o[i] = commit_i[i].valid && commit_i[i].we;
            waddr_o[i] = commit_i[i].rd;
            wdata_o[i] = commit_i[i].result;
        end
    end

endmodule

// ==== decoder.sv ====
`timescale 1ns/1ns

module decoder
    import backend_pkg::*;
(
    input logic clk,
    input logic reset_i,
    input logic pause_i,
    input logic flush_i,
    input bus32_t [ISSUE_WIDTH-1:0] pc_i,
    input bus32_t [ISSUE_WIDTH-1:0] inst_i,
    input logic [ISSUE_WIDTH-1:0] inst_valid_i,
    output logic [ISSUE_WIDTH-1:0] send_inst_en_o,
    output id_dispatch_t [ISSUE_WIDTH-1:0] dispatch_o
);

    id_dispatch_t [ISSUE_WIDTH-1:0] dec;
    logic lane1_ok;

    // unread sources stay at r0 so they never look like a dependency
    function automatic id_dispatch_t decode(input bus32_t pc, input bus32_t inst);
        id_dispatch_t d;
        alu_op_t op3r;
        d = '0;
        d.pc = pc;
        d.inst = inst;
        d.rd = inst[4:0];
        d.imm = {{20{inst[21]}}, inst[21:10]};
        d.br_off = {{14{inst[25]}}, inst[25:10], 2'b00};
        case (inst[31:15])
            OP_ADD_W: op3r = ALU_ADD;
            OP_SUB_W: op3r = ALU_SUB;
            OP_AND:   op3r = ALU_AND;
            OP_OR:    op3r = ALU_OR;
            OP_XOR:   op3r = ALU_XOR;
            OP_MUL_W: op3r = ALU_MUL;
            default:  op3r = ALU_NOP;
        endcase
        if (op3r != ALU_NOP) begin
            d.alu_op = op3r;
            d.rj = inst[9:5];
            d.rk = inst[14:10];
            d.we = 1'b1;
        end else if (inst[31:22] == OP_ADDI_W) begin
            d.alu_op = ALU_ADD;
            d.rj = inst[9:5];
            d.imm_sel = 1'b1;
            d.we = 1'b1;
        end else if (inst[31:25] == OP_LU12I_W) begin
            d.alu_op = ALU_LUI;
            d.imm = {{12{inst[24]}}, inst[24:5]};
            d.imm_sel = 1'b1;
            d.we = 1'b1;
        end else if (inst[31:26] == OP_BEQ || inst[31:26] == OP_BNE) begin
            d.alu_op = inst[26] ? ALU_BNE : ALU_BEQ;
            d.rj = inst[9:5];
            // compared against rd
            d.rk = inst[4:0];
        end else if (inst[31:26] == OP_B) begin
            d.alu_op = ALU_B;
            d.br_off = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        end
        return d;
    endfunction

    function automatic logic is_branch(input alu_op_t op);
        return op == ALU_BEQ || op == ALU_BNE || op == ALU_B;
    endfunction

    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            dec[i] = decode(pc_i[i], inst_i[i]);
        end
        lane1_ok = inst_valid_i[1] && !is_branch(dec[0].alu_op) && !is_branch(dec[1].alu_op)
                   && dec[1].alu_op != ALU_MUL
                   && !(dec[0].we && dec[0].rd != '0
                        && (dec[1].rj == dec[0].rd || dec[1].rk == dec[0].rd));
        send_inst_en_o[0] = inst_valid_i[0] && !pause_i && !flush_i && !reset_i;
        send_inst_en_o[1] = send_inst_en_o[0] && lane1_ok;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            dec[i].valid = send_inst_en_o[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            dispatch_o <= '0;
        end else if (!pause_i) begin
            dispatch_o <= dec;
        end
    end

endmodule

// ==== dispatch.sv ====
`timescale 1ns/1ns

module dispatch
    import backend_pkg::*;
(
    input logic clk,
    input logic reset_i,
    input logic pause_i,
    input logic flush_i,
    input id_dispatch_t [ISSUE_WIDTH-1:0] dispatch_i,
    input reg_pf_t [ISSUE_WIDTH-1:0] ex_reg_pf_i,
    input reg_pf_t [ISSUE_WIDTH-1:0] wb_reg_pf_i,
    dispatch_regfile.master regfile_master,
    output dispatch_ex_t [ISSUE_WIDTH-1:0] ex_o
);

    dispatch_ex_t [ISSUE_WIDTH-1:0] next;

    // later matches override earlier ones: wb then execute, lane 0 then lane 1
    function automatic bus32_t forward(
        input logic [REG_ADDR_WIDTH-1:0] addr,
        input bus32_t rf_data,
        input reg_pf_t [ISSUE_WIDTH-1:0] ex_pf,
        input reg_pf_t [ISSUE_WIDTH-1:0] wb_pf
    );
        bus32_t value;
        value = rf_data;
        if (addr != '0) begin
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (wb_pf[i].we && wb_pf[i].rd == addr) begin
                    value = wb_pf[i].data;
                end
            end
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (ex_pf[i].we && ex_pf[i].rd == addr) begin
                    value = ex_pf[i].data;
                end
            end
        end
        return value;
    endfunction

    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            regfile_master.raddr[2*i] = dispatch_i[i].rj;
            regfile_master.raddr[2*i+1] = dispatch_i[i].rk;
        end
    end

    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            next[i].valid = dispatch_i[i].valid;
            next[i].pc = dispatch_i[i].pc;
            next[i].inst = dispatch_i[i].inst;
            next[i].alu_op = dispatch_i[i].alu_op;
            next[i].rd = dispatch_i[i].rd;
            next[i].we = dispatch_i[i].we;
            next[i].br_off = dispatch_i[i].br_off;
            next[i].src1 = forward(dispatch_i[i].rj, regfile_master.rdata[2*i],
                                   ex_reg_pf_i, wb_reg_pf_i);
            if (dispatch_i[i].imm_sel) begin
                next[i].src2 = dispatch_i[i].imm;
            end else begin
                next[i].src2 = forward(dispatch_i[i].rk, regfile_master.rdata[2*i+1],
                                       ex_reg_pf_i, wb_reg_pf_i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            ex_o <= '0;
        end else if (!pause_i) begin
            ex_o <= next;
        end
    end

endmodule

// ==== execute.sv ====
`timescale 1ns/1ns

module execute
    import backend_pkg::*;
(
    input logic clk,
    input logic reset_i,
    input dispatch_ex_t [ISSUE_WIDTH-1:0] ex_i,
    output logic pause_request_o,
    output logic branch_flush_o,
    output bus32_t new_pc_o,
    output reg_pf_t [ISSUE_WIDTH-1:0] ex_reg_pf_o,
    output ex_wb_t [ISSUE_WIDTH-1:0] wb_o
);

    logic [1:0] mul_cnt;
    bus32_t mul_acc;
    bus32_t mul_sum;
    logic mul_busy;
    logic taken;
    bus32_t [ISSUE_WIDTH-1:0] result;

    function automatic bus32_t alu(input dispatch_ex_t op);
        case (op.alu_op)
            ALU_ADD: return op.src1 + op.src2;
            ALU_SUB: return op.src1 - op.src2;
            ALU_AND: return op.src1 & op.src2;
            ALU_OR:  return op.src1 | op.src2;
            ALU_XOR: return op.src1 ^ op.src2;
            ALU_LUI: return {op.src2[19:0], 12'b0};
            default: return '0;
        endcase
    endfunction

    // one byte of the multiplier per cycle, low byte first
    always_comb begin
        mul_sum = (mul_cnt == 2'd0) ? '0 : mul_acc;
        for (int b = 0; b < 8; b++) begin
            if (ex_i[0].src2[8*mul_cnt+b]) begin
                mul_sum = mul_sum + (ex_i[0].src1 << (8*mul_cnt + b));
            end
        end
    end

    assign mul_busy = ex_i[0].valid && ex_i[0].alu_op == ALU_MUL && mul_cnt != 2'd3;
    assign pause_request_o = mul_busy;

    // branches only ever sit in lane 0
    always_comb begin
        case (ex_i[0].alu_op)
            ALU_BEQ: taken = ex_i[0].src1 == ex_i[0].src2;
            ALU_BNE: taken = ex_i[0].src1 != ex_i[0].src2;
            ALU_B:   taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign branch_flush_o = ex_i[0].valid && taken;
    assign new_pc_o = ex_i[0].pc + ex_i[0].br_off;

    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            result[i] = (ex_i[i].alu_op == ALU_MUL) ? mul_sum : alu(ex_i[i]);
            ex_reg_pf_o[i].we = ex_i[i].valid && ex_i[i].we && !mul_busy;
            ex_reg_pf_o[i].rd = ex_i[i].rd;
            ex_reg_pf_o[i].data = result[i];
        end
    end

    always_ff @(posedge clk) begin
        mul_acc <= mul_sum;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mul_cnt <= '0;
            wb_o <= '0;
        end else begin
            mul_cnt <= mul_busy ? mul_cnt + 2'd1 : 2'd0;
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                wb_o[i].valid <= ex_i[i].valid && !mul_busy && !(i > 0 && branch_flush_o);
                wb_o[i].pc <= ex_i[i].pc;
                wb_o[i].inst <= ex_i[i].inst;
                wb_o[i].we <= ex_i[i].we;
                wb_o[i].rd <= ex_i[i].rd;
                wb_o[i].result <= result[i];
            end
        end
    end

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ns

module regfile
    import backend_pkg::*;
(
    input logic clk,
    input logic reset_i,
    input logic [ISSUE_WIDTH-1:0] we_i,
    input logic [ISSUE_WIDTH-1:0][REG_ADDR_WIDTH-1:0] waddr_i,
    input bus32_t [ISSUE_WIDTH-1:0] wdata_i,
    dispatch_regfile.slave slave
);

    bus32_t regs[32];

    // lane 1 is written last so it wins on a shared rd
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (we_i[i] && waddr_i[i] != '0) begin
                    regs[waddr_i[i]] <= wdata_i[i];
                end
            end
        end
    end

    // pending writes bypass to the read ports
    always_comb begin
        for (int p = 0; p < 2 * ISSUE_WIDTH; p++) begin
            slave.rdata[p] = regs[slave.raddr[p]];
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (we_i[i] && waddr_i[i] == slave.raddr[p] && slave.raddr[p] != '0) begin
                    slave.rdata[p] = wdata_i[i];
                end
            end
        end
    end

endmodule

// ==== tb_backend.sv ====
`timescale 1ns/1ns

module tb_backend
    import backend_pkg::*;
();

    localparam bus32_t BASE = 32'h1c00_0000;
    localparam int MEM_WORDS = 256;
    localparam int TIMEOUT = 2000;

    logic clk;
    logic reset_i;
    bus32_t [ISSUE_WIDTH-1:0] pc_i;
    bus32_t [ISSUE_WIDTH-1:0] inst_i;
    logic [ISSUE_WIDTH-1:0] inst_valid_i;
    logic [ISSUE_WIDTH-1:0] send_inst_en_o;
    logic branch_flush_o;
    bus32_t new_pc_o;
    logic [31:0] debug_wb_pc_o[2];
    logic [31:0] debug_wb_inst_o[2];
    logic [3:0] debug_wb_rf_wen_o[2];
    logic [4:0] debug_wb_rf_wnum_o[2];
    logic [31:0] debug_wb_rf_wdata_o[2];

    bus32_t imem[MEM_WORDS];
    int prog_len;
    bus32_t prog_end;
    bus32_t model_regs[32];

    // expected register writes in program order
    bus32_t exp_pc[$];
    bus32_t exp_inst[$];
    logic [4:0] exp_rd[$];
    bus32_t exp_data[$];
    bus32_t exp_target[$];
    // cycles in which a running mul.w must hold fetch off
    int mul_start[$];
    int mul_last_end;

    bus32_t fetch_ptr;
    int cyc;
    logic prev_flush;
    int value_errors;
    int other_errors;
    int commits;
    int flushes;
    int split_pairs;
    int stall_cycles;

    backend_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic bus32_t op3r_word(input logic [16:0] op, input int rd, input int rj,
                                         input int rk);
        return {op, 5'(rk), 5'(rj), 5'(rd)};
    endfunction

    function automatic bus32_t addi_word(input int rd, input int rj, input int imm);
        return {OP_ADDI_W, 12'(imm), 5'(rj), 5'(rd)};
    endfunction

    function automatic bus32_t lu12i_word(input int rd, input int imm);
        return {OP_LU12I_W, 20'(imm), 5'(rd)};
    endfunction

    // offsets are in words
    function automatic bus32_t cond_branch_word(input logic [5:0] op, input int rj, input int rd,
                                                input int offs);
        return {op, 16'(offs), 5'(rj), 5'(rd)};
    endfunction

    function automatic bus32_t jump_word(input int offs);
        logic [25:0] o;
        o = 26'(offs);
        return {OP_B, o[15:0], o[25:16]};
    endfunction

    function automatic logic is_alu3(input bus32_t w);
        logic [16:0] op;
        op = w[31:15];
        return op == OP_ADD_W || op == OP_SUB_W || op == OP_AND || op == OP_OR
               || op == OP_XOR || op == OP_MUL_W;
    endfunction

    function automatic logic is_mul(input bus32_t w);
        return w[31:15] == OP_MUL_W;
    endfunction

    function automatic logic is_addi(input bus32_t w);
        return w[31:22] == OP_ADDI_W;
    endfunction

    function automatic logic is_lu12i(input bus32_t w);
        return w[31:25] == OP_LU12I_W;
    endfunction

    function automatic logic is_branch(input bus32_t w);
        return w[31:26] == OP_B || w[31:26] == OP_BEQ || w[31:26] == OP_BNE;
    endfunction

    function automatic logic writes_rd(input bus32_t w);
        return is_alu3(w) || is_addi(w) || is_lu12i(w);
    endfunction

    function automatic logic reads_reg(input bus32_t w, input logic [4:0] r);
        return (is_alu3(w) && (w[9:5] == r || w[14:10] == r)) || (is_addi(w) && w[9:5] == r);
    endfunction

    // lane 1 goes with lane 0 only when independent and neither branches nor multiplies
    function automatic logic lane1_ok(input bus32_t w0, input bus32_t w1);
        return !is_branch(w0) && !is_branch(w1) && !is_mul(w1)
               && !(writes_rd(w0) && w0[4:0] != 5'd0 && reads_reg(w1, w0[4:0]));
    endfunction

    function automatic bus32_t word_at(input bus32_t addr);
        return imem[((addr - BASE) >> 2) & (MEM_WORDS - 1)];
    endfunction

    function automatic logic in_program(input bus32_t addr);
        return addr >= BASE && addr < prog_end;
    endfunction

    task automatic emit(input bus32_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic build_program();
        int rd;
        int rj;
        int rk;
        // unused words decode as nop and carry their own address
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = 32'hff00_0000 | (i << 2);
        end
        prog_len = 0;
        emit(lu12i_word(1, 20'h12345));
        emit(addi_word(1, 1, 12'h678));
        emit(addi_word(2, 0, -5));
        emit(op3r_word(OP_ADD_W, 3, 1, 2));
        emit(op3r_word(OP_SUB_W, 4, 3, 1));
        emit(op3r_word(OP_AND, 5, 4, 3));
        emit(op3r_word(OP_OR, 6, 5, 2));
        emit(op3r_word(OP_XOR, 7, 6, 1));
        emit(addi_word(0, 7, 1));
        emit(op3r_word(OP_ADD_W, 8, 0, 7));
        emit(op3r_word(OP_MUL_W, 9, 1, 2));
        emit(op3r_word(OP_ADD_W, 10, 9, 9));
        emit(op3r_word(OP_MUL_W, 11, 10, 3));
        emit(op3r_word(OP_MUL_W, 12, 11, 11));
        emit(addi_word(13, 12, 3));
        // not taken, not taken, taken
        emit(cond_branch_word(OP_BEQ, 1, 2, 3));
        emit(cond_branch_word(OP_BNE, 1, 1, 3));
        emit(cond_branch_word(OP_BEQ, 3, 3, 3));
        emit(addi_word(14, 0, 1));
        emit(addi_word(14, 0, 2));
        emit(addi_word(15, 0, 7));
        emit(jump_word(2));
        emit(addi_word(15, 0, 9));
        // small countdown loop
        emit(addi_word(16, 0, 3));
        emit(addi_word(16, 16, -1));
        emit(op3r_word(OP_ADD_W, 17, 17, 16));
        emit(cond_branch_word(OP_BNE, 16, 0, -2));
        emit(cond_branch_word(OP_BNE, 1, 2, 2));
        emit(lu12i_word(18, 1));
        emit(op3r_word(OP_ADD_W, 18, 17, 15));
        for (int n = 0; n < 48; n++) begin
            rd = $urandom % 8;
            rj = $urandom % 8;
            rk = $urandom % 8;
            case ($urandom % 7)
                0: emit(op3r_word(OP_ADD_W, rd, rj, rk));
                1: emit(op3r_word(OP_SUB_W, rd, rj, rk));
                2: emit(op3r_word(OP_AND, rd, rj, rk));
                3: emit(op3r_word(OP_OR, rd, rj, rk));
                4: emit(op3r_word(OP_XOR, rd, rj, rk));
                5: emit(addi_word(rd, rj, $urandom));
                default: emit(lu12i_word(rd, $urandom));
            endcase
        end
        prog_end = BASE + 4 * prog_len;
    endtask

    task automatic run_model();
        bus32_t pc;
        bus32_t w;
        bus32_t a;
        bus32_t b;
        bus32_t res;
        bus32_t target;
        logic [63:0] prod;
        logic taken;
        int steps;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        pc = BASE;
        steps = 0;
        while (pc != prog_end && steps < 1000) begin
            w = word_at(pc);
            a = model_regs[w[9:5]];
            b = model_regs[w[14:10]];
            res = '0;
            taken = 1'b0;
            target = pc + 4;
            if (is_alu3(w)) begin
                prod = 64'(a) * 64'(b);
                case (w[31:15])
                    OP_ADD_W: res = a + b;
                    OP_SUB_W: res = a - b;
                    OP_AND:   res = a & b;
                    OP_OR:    res = a | b;
                    OP_XOR:   res = a ^ b;
                    default:  res = prod[31:0];
                endcase
            end else if (is_addi(w)) begin
                res = a + {{20{w[21]}}, w[21:10]};
            end else if (is_lu12i(w)) begin
                res = {w[24:5], 12'h000};
            end else if (w[31:26] == OP_B) begin
                taken = 1'b1;
                target = pc + {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
            end else if (is_branch(w)) begin
                // beq and bne compare rj with the rd field
                taken = (w[31:26] == OP_BEQ) ? (a == model_regs[w[4:0]])
                                             : (a != model_regs[w[4:0]]);
                target = pc + {{14{w[25]}}, w[25:10], 2'b00};
            end
            if (writes_rd(w)) begin
                exp_pc.push_back(pc);
                exp_inst.push_back(w);
                exp_rd.push_back(w[4:0]);
                exp_data.push_back(res);
                if (w[4:0] != 5'd0) begin
                    model_regs[w[4:0]] = res;
                end
            end
            if (taken) begin
                exp_target.push_back(target);
            end
            pc = taken ? target : pc + 4;
            steps++;
        end
    endtask

    task automatic compare_value(input string name, input bus32_t got, input bus32_t exp);
        assert (got === exp) else begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        other_errors++;
    endtask

    // drives one cycle on the falling edge and checks in the low phase
    task automatic run_cycle();
        logic [ISSUE_WIDTH-1:0] en;
        int start;
        @(negedge clk);
        cyc++;
        pc_i[0] = fetch_ptr;
        pc_i[1] = fetch_ptr + 4;
        inst_i[0] = word_at(fetch_ptr);
        inst_i[1] = word_at(fetch_ptr + 4);
        inst_valid_i[0] = in_program(fetch_ptr);
        inst_valid_i[1] = in_program(fetch_ptr) && in_program(fetch_ptr + 4);
        #5;
        en = send_inst_en_o;
        assert (!(en[1] && !en[0])) else report_failure("lane 1 accepted without lane 0");
        if (en[0] && inst_valid_i[1]) begin
            compare_value("send_inst_en_o", 32'(en),
                          {30'b0, lane1_ok(inst_i[0], inst_i[1]), 1'b1});
            if (!en[1]) begin
                split_pairs++;
            end
        end
        if (mul_start.size() > 0 && mul_start[0] + 2 < cyc) begin
            void'(mul_start.pop_front());
        end
        if (mul_start.size() > 0 && mul_start[0] <= cyc) begin
            stall_cycles++;
            compare_value("send_inst_en_o", 32'(en), 32'h0);
        end
        if (branch_flush_o) begin
            flushes++;
            compare_value("send_inst_en_o", 32'(en), 32'h0);
            assert (!prev_flush) else report_failure("branch_flush_o stayed high two cycles");
            if (exp_target.size() == 0) begin
                report_failure("branch flush with no taken branch left in the program");
            end else begin
                compare_value("new_pc_o", new_pc_o, exp_target.pop_front());
            end
            // anything younger than the branch is gone
            mul_start.delete();
            mul_last_end = -10;
        end
        prev_flush = branch_flush_o;
        if (en[0] && is_mul(inst_i[0])) begin
            start = (cyc + 2 > mul_last_end + 2) ? cyc + 2 : mul_last_end + 2;
            mul_start.push_back(start);
            mul_last_end = start + 2;
        end
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            if (debug_wb_rf_wen_o[i] != 4'h0) begin
                compare_value($sformatf("debug_wb_rf_wen_o[%0d]", i),
                              32'(debug_wb_rf_wen_o[i]), 32'hf);
                if (exp_pc.size() == 0) begin
                    report_failure($sformatf("lane %0d committed pc %h after the last write",
                                             i, debug_wb_pc_o[i]));
                end else begin
                    compare_value($sformatf("debug_wb_pc_o[%0d]", i), debug_wb_pc_o[i],
                                  exp_pc.pop_front());
                    compare_value($sformatf("debug_wb_inst_o[%0d]", i), debug_wb_inst_o[i],
                                  exp_inst.pop_front());
                    compare_value($sformatf("debug_wb_rf_wnum_o[%0d]", i),
                                  32'(debug_wb_rf_wnum_o[i]), 32'(exp_rd.pop_front()));
                    compare_value($sformatf("debug_wb_rf_wdata_o[%0d]", i),
                                  debug_wb_rf_wdata_o[i], exp_data.pop_front());
                    commits++;
                end
            end
        end
        if (branch_flush_o) begin
            fetch_ptr = new_pc_o;
        end else begin
            fetch_ptr = fetch_ptr + (en[1] ? 32'd8 : en[0] ? 32'd4 : 32'd0);
        end
    endtask

    initial begin
        void'($urandom(32'h932d));
        reset_i = 1'b1;
        value_errors = 0;
        other_errors = 0;
        commits = 0;
        flushes = 0;
        split_pairs = 0;
        stall_cycles = 0;
        build_program();
        run_model();
        // the first pair is already offered while reset is held
        pc_i[0] = BASE;
        pc_i[1] = BASE + 4;
        inst_i[0] = word_at(BASE);
        inst_i[1] = word_at(BASE + 4);
        inst_valid_i = '1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        assert (send_inst_en_o == '0 && !branch_flush_o && debug_wb_rf_wen_o[0] == 4'h0
                && debug_wb_rf_wen_o[1] == 4'h0)
            else report_failure("outputs not idle during reset");
        inst_valid_i = '0;
        reset_i = 1'b0;
        fetch_ptr = BASE;
        cyc = 0;
        prev_flush = 1'b0;
        mul_last_end = -10;
        while (exp_pc.size() > 0 && cyc < TIMEOUT) begin
            run_cycle();
        end
        if (exp_pc.size() > 0) begin
            report_failure($sformatf("timeout after %0d cycles with %0d writes not committed",
                                     cyc, exp_pc.size()));
        end
        // a few idle cycles to catch stray commits
        repeat (10) run_cycle();
        if (exp_target.size() > 0) begin
            report_failure("taken branches that never flushed the pipeline");
        end
        $display("%s%s",
                 $sformatf("commits %0d, flushes %0d, split pairs %0d, mul stall cycles %0d, ",
                           commits, flushes, split_pairs, stall_cycles),
                 $sformatf("%0d value errors, %0d other errors", value_errors, other_errors));
        if (value_errors + other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
backend_pkg.sv
backend_if.sv
decoder.sv
dispatch.sv
execute.sv
wb.sv
regfile.sv
ctrl.sv
backend_top.sv
tb_backend.sv

// ==== wb.sv ====
`timescale 1ns/1ns

module wb
    import backend_pkg::*;
(
    input logic clk,
    input logic reset_i,
    input logic flush_i,
    input ex_wb_t [ISSUE_WIDTH-1:0] wb_i,
    output reg_pf_t [ISSUE_WIDTH-1:0] wb_reg_pf_o,
    output ex_wb_t [ISSUE_WIDTH-1:0] wb_o
);

    // results arriving from execute's register are forwarded here,
    // the committed pair reaches dispatch through the regfile bypass
    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            wb_reg_pf_o[i].we = wb_i[i].valid && wb_i[i].we;
            wb_reg_pf_o[i].rd = wb_i[i].rd;
            wb_reg_pf_o[i].data = wb_i[i].result;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            wb_o <= '0;
        end else begin
            wb_o <= wb_i;
        end
    end

endmodule
